// File: logic/pinmux_pkg.sv
// Pad counts, pad index map, function-select struct and GPIO word union
`default_nettype none

package pinmux_pkg;

  //--------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------
  localparam int NUM_PADS = 28;
  localparam int GPIO_W   = 32;
  localparam int PORT_W   = 8;

  // Function counts
  localparam int NUM_PWM  = 6;
  localparam int NUM_UART = 2;
  localparam int NUM_INT  = 2;
  localparam int NUM_SS   = 4;
  localparam int STRAP_W  = 8;

  //--------------------------------------------------------------------
  // Pad indices of the function pins
  //--------------------------------------------------------------------
  localparam int PAD_RXD0 = 6;
  localparam int PAD_TXD0 = 7;
  // RXD1 and INT0 share this pad
  localparam int PAD_RXD1 = 8;
  localparam int PAD_INT1 = 9;
  localparam int PAD_TXD1 = 10;
  localparam int PAD_MOSI = 19;
  localparam int PAD_MISO = 20;
  localparam int PAD_SCK  = 21;
  localparam int PAD_SDA  = 26;
  localparam int PAD_SCL  = 27;

  // First strap pad, strap covers 13 to 20
  localparam int STRAP_LO = 13;

  // PWM channel n drives pad PWM_PAD[n]
  localparam int PWM_PAD [NUM_PWM] = '{9, 13, 14, 17, 18, 19};
  // Chip select n drives pad SS_PAD[n]
  localparam int SS_PAD  [NUM_SS]  = '{18, 17, 14, 13};

  //--------------------------------------------------------------------
  // Port bit to pad tables, index is the bit inside the port byte
  //--------------------------------------------------------------------
  localparam int PORT_B_PAD [PORT_W]   = '{16, 17, 18, 19, 20, 21, 11, 12};
  // Port C bit 7 has no pad
  localparam int PORT_C_PAD [PORT_W-1] = '{22, 23, 24, 25, 26, 27, 5};
  localparam int PORT_D_PAD [PORT_W]   = '{6, 7, 8, 9, 10, 13, 14, 15};

  // Function-select word, bit 0 is pwm_enb[0]
  typedef struct packed {
    logic [15:0]        rsvd;
    logic               i2cm_enb;
    logic [NUM_SS-1:0]  spim_cs_enb;
    logic               spim_enb;
    logic [NUM_UART-1:0] uart_enb;
    logic [NUM_INT-1:0] int_enb;
    logic [NUM_PWM-1:0] pwm_enb;
  } func_sel_t;

  // GPIO word, flat or per port byte, port A in the low byte
  typedef union packed {
    logic [GPIO_W-1:0] word;
    struct packed {
      logic [PORT_W-1:0] port_d;
      logic [PORT_W-1:0] port_c;
      logic [PORT_W-1:0] port_b;
      logic [PORT_W-1:0] port_a;
    } port;
  } gpio_word_u;

endpackage

`default_nettype wire

// File: logic/pinmux_cfg_if.sv
// Registered configuration bundle with decoder and pad-stage modports
`timescale 1ns/1ps
`default_nettype none

interface pinmux_cfg_if ();

  // Peripheral enables, one field per function
  pinmux_pkg::func_sel_t  func;

  // GPIO direction per port bit
  // 1 means the pad drives
  pinmux_pkg::gpio_word_u dir_sel;

  // Keeps pads 13 to 20 as inputs
  logic                   strap_ctrl;

  //--------------------------------------------------------------------
  // Views
  //--------------------------------------------------------------------
  // Register side
  modport decoder (
    output func,
    output dir_sel,
    output strap_ctrl
  );

  // Drive and sample stages only read
  modport pad_stage (
    input func,
    input dir_sel,
    input strap_ctrl
  );

endinterface

`default_nettype wire

// File: logic/pinmux_cfg_decode.sv
// Configuration register for function select, GPIO direction and strap control
`timescale 1ns/1ps
`default_nettype none

module pinmux_cfg_decode (
  input  logic                           mclk,
  input  logic                           rst_n_i,
  input  pinmux_pkg::func_sel_t          func_sel_i,
  input  pinmux_pkg::gpio_word_u         dir_sel_i,
  input  logic                           strap_ctrl_i,
  pinmux_cfg_if.decoder                  cfg,
  output logic [pinmux_pkg::NUM_PWM-1:0] cfg_pwm_enb_o
);

  // Registered copies of the configuration words
  pinmux_pkg::func_sel_t  func_q;
  pinmux_pkg::gpio_word_u dir_q;
  logic                   strap_q;

  //--------------------------------------------------------------------
  // Configuration register
  //--------------------------------------------------------------------
  // One cycle from the sampling edge to the pads
  always_ff @(posedge mclk) begin
    if (!rst_n_i) begin
      // All functions off, every pad an input
      func_q  <= '0;
      dir_q   <= '0;
      strap_q <= 1'b0;
    end else begin
      func_q  <= func_sel_i;
      dir_q   <= dir_sel_i;
      strap_q <= strap_ctrl_i;
    end
  end

  //--------------------------------------------------------------------
  // Field split towards the pad stages
  //--------------------------------------------------------------------
  // Whole function word, stages pick their own fields
  assign cfg.func       = func_q;

  // Direction word, read per port byte downstream
  assign cfg.dir_sel    = dir_q;

  // Strap hold
  assign cfg.strap_ctrl = strap_q;

  // PWM block sees its enables straight from the register
  assign cfg_pwm_enb_o  = func_q.pwm_enb;

  // Upper half of the function word has no function behind it
  rsvd_clear_chk: assert property (
    @(posedge mclk) disable iff (!rst_n_i)
    func_q.rsvd == '0
  ) else $error("reserved function-select bits set in register");

endmodule

`default_nettype wire

// File: logic/pinmux_pad_drive.sv
// Pad output value and output-enable selection by fixed function priority
`timescale 1ns/1ps
`default_nettype none

module pinmux_pad_drive (
  pinmux_cfg_if.pad_stage                 cfg,
  input  pinmux_pkg::gpio_word_u          gpio_out_i,
  input  logic [pinmux_pkg::NUM_PWM-1:0]  pwm_wfm_i,
  input  logic [pinmux_pkg::NUM_UART-1:0] uart_txd_i,
  input  logic                            spim_sck_i,
  input  logic [pinmux_pkg::NUM_SS-1:0]   spim_ssn_i,
  input  logic                            spim_miso_i,
  input  logic                            i2cm_sda_out_i,
  input  logic                            i2cm_sda_oen_i,
  input  logic                            i2cm_scl_out_i,
  input  logic                            i2cm_scl_oen_i,
  output logic [pinmux_pkg::NUM_PADS-1:0] pad_out_o,
  output logic [pinmux_pkg::NUM_PADS-1:0] pad_oen_o
);

  // Layers go from lowest to highest priority
  // a later layer overwrites an earlier one on the same pad
  always_comb begin
    // Idle pad: value 0, input
    pad_out_o = '0;
    pad_oen_o = '1;

    //------------------------------------------------------------------
    // GPIO, drives only where the dir bit is set
    //------------------------------------------------------------------
    for (int k = 0; k < pinmux_pkg::PORT_W; k++) begin
      if (cfg.dir_sel.port.port_b[k]) begin
        pad_out_o[pinmux_pkg::PORT_B_PAD[k]] = gpio_out_i.port.port_b[k];
        pad_oen_o[pinmux_pkg::PORT_B_PAD[k]] = 1'b0;
      end
      if (cfg.dir_sel.port.port_d[k]) begin
        pad_out_o[pinmux_pkg::PORT_D_PAD[k]] = gpio_out_i.port.port_d[k];
        pad_oen_o[pinmux_pkg::PORT_D_PAD[k]] = 1'b0;
      end
    end

    // Port C has no bit 7 pad
    for (int k = 0; k < pinmux_pkg::PORT_W - 1; k++) begin
      if (cfg.dir_sel.port.port_c[k]) begin
        pad_out_o[pinmux_pkg::PORT_C_PAD[k]] = gpio_out_i.port.port_c[k];
        pad_oen_o[pinmux_pkg::PORT_C_PAD[k]] = 1'b0;
      end
    end

    // I2C master owns both the value and the enable
    if (cfg.func.i2cm_enb) begin
      pad_out_o[pinmux_pkg::PAD_SDA] = i2cm_sda_out_i;
      pad_oen_o[pinmux_pkg::PAD_SDA] = i2cm_sda_oen_i;
      pad_out_o[pinmux_pkg::PAD_SCL] = i2cm_scl_out_i;
      pad_oen_o[pinmux_pkg::PAD_SCL] = i2cm_scl_oen_i;
    end

    //------------------------------------------------------------------
    // Input functions turn the pad around
    //------------------------------------------------------------------
    // RXD0
    if (cfg.func.uart_enb[0]) begin
      pad_oen_o[pinmux_pkg::PAD_RXD0] = 1'b1;
    end
    // Pad 8 is input for RXD1 or INT0, value stays GPIO
    if (cfg.func.uart_enb[1] || cfg.func.int_enb[0]) begin
      pad_oen_o[pinmux_pkg::PAD_RXD1] = 1'b1;
    end
    // INT1, PWM0 further down takes the pad back
    if (cfg.func.int_enb[1]) begin
      pad_oen_o[pinmux_pkg::PAD_INT1] = 1'b1;
    end

    //------------------------------------------------------------------
    // Output functions
    //------------------------------------------------------------------
    // SPI master clock and MISO
    if (cfg.func.spim_enb) begin
      pad_out_o[pinmux_pkg::PAD_SCK]  = spim_sck_i;
      pad_oen_o[pinmux_pkg::PAD_SCK]  = 1'b0;
      pad_out_o[pinmux_pkg::PAD_MISO] = spim_miso_i;
      pad_oen_o[pinmux_pkg::PAD_MISO] = 1'b0;
    end

    // UART transmit lines
    if (cfg.func.uart_enb[0]) begin
      pad_out_o[pinmux_pkg::PAD_TXD0] = uart_txd_i[0];
      pad_oen_o[pinmux_pkg::PAD_TXD0] = 1'b0;
    end
    if (cfg.func.uart_enb[1]) begin
      pad_out_o[pinmux_pkg::PAD_TXD1] = uart_txd_i[1];
      pad_oen_o[pinmux_pkg::PAD_TXD1] = 1'b0;
    end

    // Chip selects, below PWM on the shared pads
    for (int i = 0; i < pinmux_pkg::NUM_SS; i++) begin
      if (cfg.func.spim_cs_enb[i]) begin
        pad_out_o[pinmux_pkg::SS_PAD[i]] = spim_ssn_i[i];
        pad_oen_o[pinmux_pkg::SS_PAD[i]] = 1'b0;
      end
    end

    // PWM has top value priority
    for (int i = 0; i < pinmux_pkg::NUM_PWM; i++) begin
      if (cfg.func.pwm_enb[i]) begin
        pad_out_o[pinmux_pkg::PWM_PAD[i]] = pwm_wfm_i[i];
        pad_oen_o[pinmux_pkg::PWM_PAD[i]] = 1'b0;
      end
    end

    // MOSI input wins the enable over PWM5 on pad 19
    if (cfg.func.spim_enb) begin
      pad_oen_o[pinmux_pkg::PAD_MOSI] = 1'b1;
    end

    // Strap hold beats everything
    if (cfg.strap_ctrl) begin
      pad_oen_o[pinmux_pkg::STRAP_LO +: pinmux_pkg::STRAP_W] = '1;
    end
  end

  // Strap pads must never drive while the hold is on
  strap_oen_chk: assert final (
    !cfg.strap_ctrl || (&pad_oen_o[pinmux_pkg::STRAP_LO +: pinmux_pkg::STRAP_W])
  ) else $error("strap pad driven while strap control set");

endmodule

`default_nettype wire

// File: logic/pinmux_pad_sample.sv
// Pad input steering to GPIO ports, peripheral inputs and strap capture
`timescale 1ns/1ps
`default_nettype none

module pinmux_pad_sample (
  pinmux_cfg_if.pad_stage                 cfg,
  input  logic [pinmux_pkg::NUM_PADS-1:0] pad_in_i,
  output pinmux_pkg::gpio_word_u          gpio_in_o,
  output logic [pinmux_pkg::STRAP_W-1:0]  pad_strap_o,
  output logic [pinmux_pkg::NUM_UART-1:0] uart_rxd_o,
  output logic [pinmux_pkg::NUM_INT-1:0]  ext_intr_o,
  output logic                            spim_mosi_o,
  output logic                            i2cm_sda_in_o,
  output logic                            i2cm_scl_in_o
);

  // Pad 8 owners with RXD1 ahead of INT0
  logic rxd1_sel;
  logic int0_sel;

  assign rxd1_sel = cfg.func.uart_enb[1];
  assign int0_sel = cfg.func.int_enb[0] & ~cfg.func.uart_enb[1];

  //--------------------------------------------------------------------
  // GPIO ports copied regardless of function
  //--------------------------------------------------------------------
  always_comb begin
    // No port A and no pad behind C7
    gpio_in_o = '0;
    for (int k = 0; k < pinmux_pkg::PORT_W; k++) begin
      gpio_in_o.port.port_b[k] = pad_in_i[pinmux_pkg::PORT_B_PAD[k]];
      gpio_in_o.port.port_d[k] = pad_in_i[pinmux_pkg::PORT_D_PAD[k]];
    end
    for (int k = 0; k < pinmux_pkg::PORT_W - 1; k++) begin
      gpio_in_o.port.port_c[k] = pad_in_i[pinmux_pkg::PORT_C_PAD[k]];
    end
  end

  //--------------------------------------------------------------------
  // Peripheral inputs gated by their enables
  //--------------------------------------------------------------------
  // Idle UART line is high
  assign uart_rxd_o[0] = cfg.func.uart_enb[0] ? pad_in_i[pinmux_pkg::PAD_RXD0] : 1'b1;
  assign uart_rxd_o[1] = rxd1_sel ? pad_in_i[pinmux_pkg::PAD_RXD1] : 1'b1;

  // Level interrupts
  assign ext_intr_o[0] = int0_sel & pad_in_i[pinmux_pkg::PAD_RXD1];
  assign ext_intr_o[1] = cfg.func.int_enb[1] & pad_in_i[pinmux_pkg::PAD_INT1];

  // SPI master data in
  assign spim_mosi_o   = cfg.func.spim_enb & pad_in_i[pinmux_pkg::PAD_MOSI];

  // I2C line readback
  assign i2cm_sda_in_o = cfg.func.i2cm_enb & pad_in_i[pinmux_pkg::PAD_SDA];
  assign i2cm_scl_in_o = cfg.func.i2cm_enb & pad_in_i[pinmux_pkg::PAD_SCL];

  // Strap byte straight from pads 13 to 20
  assign pad_strap_o   = pad_in_i[pinmux_pkg::STRAP_LO +: pinmux_pkg::STRAP_W];

  // INT0 output stays low while RXD1 owns pad 8
  pad8_owner_chk: assert final (!(cfg.func.uart_enb[1] && ext_intr_o[0]))
    else $error("pad 8 steered to both RXD1 and INT0");

endmodule

`default_nettype wire

// File: logic/pinmux_top.sv
// Pad multiplexer top level, config register plus pad drive and sample stages
`timescale 1ns/1ps
`default_nettype none

module pinmux_top (
  input  logic                                       mclk,
  input  logic                                       rst_n_i,

  // Configuration
  input  logic                                       cfg_strap_pad_ctrl_i,
  input  logic [pinmux_pkg::GPIO_W-1:0]              cfg_gpio_dir_sel_i,
  input  logic [$bits(pinmux_pkg::func_sel_t)-1:0]   cfg_multi_func_sel_i,

  // Pads
  input  logic [pinmux_pkg::NUM_PADS-1:0]            pad_in_i,
  output logic [pinmux_pkg::NUM_PADS-1:0]            pad_out_o,
  output logic [pinmux_pkg::NUM_PADS-1:0]            pad_oen_o,
  output logic [pinmux_pkg::STRAP_W-1:0]             pad_strap_o,

  // PWM and interrupts
  output logic [pinmux_pkg::NUM_PWM-1:0]             cfg_pwm_enb_o,
  input  logic [pinmux_pkg::NUM_PWM-1:0]             pwm_wfm_i,
  output logic [pinmux_pkg::NUM_INT-1:0]             ext_intr_o,

  // GPIO
  output logic [pinmux_pkg::GPIO_W-1:0]              gpio_in_o,
  input  logic [pinmux_pkg::GPIO_W-1:0]              gpio_out_i,

  // UART
  input  logic [pinmux_pkg::NUM_UART-1:0]            uart_txd_i,
  output logic [pinmux_pkg::NUM_UART-1:0]            uart_rxd_o,

  // SPI master
  input  logic                                       spim_sck_i,
  input  logic [pinmux_pkg::NUM_SS-1:0]              spim_ssn_i,
  input  logic                                       spim_miso_i,
  output logic                                       spim_mosi_o,

  // I2C master
  input  logic                                       i2cm_sda_out_i,
  input  logic                                       i2cm_sda_oen_i,
  output logic                                       i2cm_sda_in_o,
  input  logic                                       i2cm_scl_out_i,
  input  logic                                       i2cm_scl_oen_i,
  output logic                                       i2cm_scl_in_o
);

  // Flat words seen as port bytes inside
  pinmux_pkg::gpio_word_u dir_w;
  pinmux_pkg::gpio_word_u gpio_out_w;
  pinmux_pkg::gpio_word_u gpio_in_w;

  assign dir_w.word      = cfg_gpio_dir_sel_i;
  assign gpio_out_w.word = gpio_out_i;
  assign gpio_in_o       = gpio_in_w.word;

  // Registered configuration shared by both pad stages
  pinmux_cfg_if u_cfg_if ();

  //--------------------------------------------------------------------
  // Decode
  //--------------------------------------------------------------------
  pinmux_cfg_decode u_cfg_decode (
    .mclk          (mclk),
    .rst_n_i       (rst_n_i),
    .func_sel_i    (cfg_multi_func_sel_i),
    .dir_sel_i     (dir_w),
    .strap_ctrl_i  (cfg_strap_pad_ctrl_i),
    .cfg           (u_cfg_if.decoder),
    .cfg_pwm_enb_o (cfg_pwm_enb_o)
  );

  // Outbound pad path
  pinmux_pad_drive u_pad_drive (
    .cfg            (u_cfg_if.pad_stage),
    .gpio_out_i     (gpio_out_w),
    .pwm_wfm_i      (pwm_wfm_i),
    .uart_txd_i     (uart_txd_i),
    .spim_sck_i     (spim_sck_i),
    .spim_ssn_i     (spim_ssn_i),
    .spim_miso_i    (spim_miso_i),
    .i2cm_sda_out_i (i2cm_sda_out_i),
    .i2cm_sda_oen_i (i2cm_sda_oen_i),
    .i2cm_scl_out_i (i2cm_scl_out_i),
    .i2cm_scl_oen_i (i2cm_scl_oen_i),
    .pad_out_o      (pad_out_o),
    .pad_oen_o      (pad_oen_o)
  );

  // Inbound pad path
  pinmux_pad_sample u_pad_sample (
    .cfg           (u_cfg_if.pad_stage),
    .pad_in_i      (pad_in_i),
    .gpio_in_o     (gpio_in_w),
    .pad_strap_o   (pad_strap_o),
    .uart_rxd_o    (uart_rxd_o),
    .ext_intr_o    (ext_intr_o),
    .spim_mosi_o   (spim_mosi_o),
    .i2cm_sda_in_o (i2cm_sda_in_o),
    .i2cm_scl_in_o (i2cm_scl_in_o)
  );

endmodule

`default_nettype wire

// File: verification/pinmux_tb_clkgen.sv
// Free-running testbench clock source, 4 ns period
`timescale 1ns/1ps
`default_nettype none

module pinmux_tb_clkgen (
  output logic clk_o
);

  // Half of the 4 ns period
  localparam realtime HALF_PERIOD = 2.0;

  // Starts low, first rising edge at 2 ns
  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: verification/pinmux_tb.sv
// Pad multiplexer testbench with LFSR stimulus, reference model, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module pinmux_tb;

  localparam int NP = pinmux_pkg::NUM_PADS;

  // Test lengths in clock cycles
  localparam int RST_CYC     = 3;
  localparam int GPIO_CYC    = 150;
  localparam int RAND_CYC    = 300;
  localparam int STRAP_CYC   = 100;
  localparam int LAT_ITER    = 30;
  localparam int LAT_CYC     = 3 * LAT_ITER;
  localparam int CYCLE_LIMIT = RST_CYC + GPIO_CYC + RAND_CYC + STRAP_CYC + LAT_CYC + 20;

  // Taps of x^32 + x^22 + x^2 + x + 1 for a right shift
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [31:0] LFSR_SEED = 32'd95277;

  // Pad sample results and PWM enables in one word
  typedef struct packed {
    logic [pinmux_pkg::NUM_UART-1:0] uart_rxd;
    logic [pinmux_pkg::NUM_INT-1:0]  ext_intr;
    logic                            spim_mosi;
    logic                            sda_in;
    logic                            scl_in;
    logic [pinmux_pkg::STRAP_W-1:0]  strap;
    logic [pinmux_pkg::NUM_PWM-1:0]  pwm_enb;
  } periph_t;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic                                  cfg_strap;
  logic [pinmux_pkg::GPIO_W-1:0]         cfg_dir;
  pinmux_pkg::func_sel_t                 cfg_func;
  logic [NP-1:0]                         pad_in;
  logic [pinmux_pkg::GPIO_W-1:0]         gpio_out;
  logic [pinmux_pkg::NUM_PWM-1:0]        pwm_wfm;
  logic [pinmux_pkg::NUM_UART-1:0]       uart_txd;
  logic                                  spim_sck;
  logic [pinmux_pkg::NUM_SS-1:0]         spim_ssn;
  logic                                  spim_miso;
  logic                                  sda_out;
  logic                                  sda_oen;
  logic                                  scl_out;
  logic                                  scl_oen;

  // DUT outputs
  logic [NP-1:0]                         pad_out;
  logic [NP-1:0]                         pad_oen;
  logic [pinmux_pkg::STRAP_W-1:0]        pad_strap;
  logic [pinmux_pkg::NUM_PWM-1:0]        pwm_enb;
  logic [pinmux_pkg::NUM_INT-1:0]        ext_intr;
  pinmux_pkg::gpio_word_u                gpio_in;
  logic [pinmux_pkg::NUM_UART-1:0]       uart_rxd;
  logic                                  spim_mosi;
  logic                                  sda_in;
  logic                                  scl_in;

  // Model copy of the configuration register
  pinmux_pkg::func_sel_t                 m_func;
  pinmux_pkg::gpio_word_u                m_dir;
  logic                                  m_strap;

  logic [31:0] lfsr_q;
  int          pad_errs;
  int          gpio_errs;
  int          periph_errs;
  int          cycle_cnt;
  logic [NP-1:0] saved_out;
  logic [NP-1:0] saved_oen;

  pinmux_tb_clkgen u_clkgen (.clk_o(clk));

  pinmux_top UUT (
    .mclk                 (clk),
    .rst_n_i              (rst_n),
    .cfg_strap_pad_ctrl_i (cfg_strap),
    .cfg_gpio_dir_sel_i   (cfg_dir),
    .cfg_multi_func_sel_i (cfg_func),
    .pad_in_i             (pad_in),
    .pad_out_o            (pad_out),
    .pad_oen_o            (pad_oen),
    .pad_strap_o          (pad_strap),
    .cfg_pwm_enb_o        (pwm_enb),
    .pwm_wfm_i            (pwm_wfm),
    .ext_intr_o           (ext_intr),
    .gpio_in_o            (gpio_in),
    .gpio_out_i           (gpio_out),
    .uart_txd_i           (uart_txd),
    .uart_rxd_o           (uart_rxd),
    .spim_sck_i           (spim_sck),
    .spim_ssn_i           (spim_ssn),
    .spim_miso_i          (spim_miso),
    .spim_mosi_o          (spim_mosi),
    .i2cm_sda_out_i       (sda_out),
    .i2cm_sda_oen_i       (sda_oen),
    .i2cm_sda_in_o        (sda_in),
    .i2cm_scl_out_i       (scl_out),
    .i2cm_scl_oen_i       (scl_oen),
    .i2cm_scl_in_o        (scl_in)
  );

  // Model register on the same edge as the DUT
  always @(posedge clk) begin
    if (!rst_n) begin
      m_func  <= '0;
      m_dir   <= '0;
      m_strap <= 1'b0;
    end else begin
      m_func  <= cfg_func;
      m_dir   <= cfg_dir;
      m_strap <= cfg_strap;
    end
  end

  //--------------------------------------------------------------------
  // Random numbers
  //--------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ LFSR_TAPS;
    end
    return s;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------
  // GPIO word bit of a pad or -1 when the pad has no port bit
  function automatic int gpio_bit_of_pad(input int p);
    if (p >= 6 && p <= 10) return 24 + (p - 6);
    if (p >= 13 && p <= 15) return 29 + (p - 13);
    if (p >= 16 && p <= 21) return 8 + (p - 16);
    if (p == 11 || p == 12) return 14 + (p - 11);
    if (p >= 22 && p <= 27) return 16 + (p - 22);
    if (p == 5) return 22;
    return -1;
  endfunction

  // Pad driven by PWM, chip select, UART TX or SPI master
  function automatic logic out_fn_active(input int p);
    for (int i = 0; i < pinmux_pkg::NUM_PWM; i++) begin
      if (m_func.pwm_enb[i] && pinmux_pkg::PWM_PAD[i] == p) return 1'b1;
    end
    for (int i = 0; i < pinmux_pkg::NUM_SS; i++) begin
      if (m_func.spim_cs_enb[i] && pinmux_pkg::SS_PAD[i] == p) return 1'b1;
    end
    if (m_func.uart_enb[0] && p == pinmux_pkg::PAD_TXD0) return 1'b1;
    if (m_func.uart_enb[1] && p == pinmux_pkg::PAD_TXD1) return 1'b1;
    if (m_func.spim_enb && (p == pinmux_pkg::PAD_SCK || p == pinmux_pkg::PAD_MISO)) return 1'b1;
    return 1'b0;
  endfunction

  // First applicable rule wins
  function automatic logic pad_value(input int p);
    int g;
    g = gpio_bit_of_pad(p);
    for (int i = 0; i < pinmux_pkg::NUM_PWM; i++) begin
      if (m_func.pwm_enb[i] && pinmux_pkg::PWM_PAD[i] == p) return pwm_wfm[i];
    end
    for (int i = 0; i < pinmux_pkg::NUM_SS; i++) begin
      if (m_func.spim_cs_enb[i] && pinmux_pkg::SS_PAD[i] == p) return spim_ssn[i];
    end
    if (m_func.uart_enb[0] && p == pinmux_pkg::PAD_TXD0) return uart_txd[0];
    if (m_func.uart_enb[1] && p == pinmux_pkg::PAD_TXD1) return uart_txd[1];
    if (m_func.spim_enb && p == pinmux_pkg::PAD_SCK) return spim_sck;
    if (m_func.spim_enb && p == pinmux_pkg::PAD_MISO) return spim_miso;
    if (m_func.i2cm_enb && p == pinmux_pkg::PAD_SDA) return sda_out;
    if (m_func.i2cm_enb && p == pinmux_pkg::PAD_SCL) return scl_out;
    if (g >= 0 && m_dir.word[g]) return gpio_out[g];
    return 1'b0;
  endfunction

  // Strap hold, then MOSI over PWM5, then outputs, inputs, I2C, GPIO
  function automatic logic pad_oen_exp(input int p);
    int g;
    g = gpio_bit_of_pad(p);
    if (m_strap && p >= 13 && p <= 20) return 1'b1;
    if (m_func.spim_enb && p == pinmux_pkg::PAD_MOSI) return 1'b1;
    if (out_fn_active(p)) return 1'b0;
    if (m_func.uart_enb[0] && p == pinmux_pkg::PAD_RXD0) return 1'b1;
    if ((m_func.uart_enb[1] || m_func.int_enb[0]) && p == pinmux_pkg::PAD_RXD1) return 1'b1;
    if (m_func.int_enb[1] && p == pinmux_pkg::PAD_INT1) return 1'b1;
    if (m_func.i2cm_enb && p == pinmux_pkg::PAD_SDA) return sda_oen;
    if (m_func.i2cm_enb && p == pinmux_pkg::PAD_SCL) return scl_oen;
    if (g >= 0 && m_dir.word[g]) return 1'b0;
    return 1'b1;
  endfunction

  // Port A and C7 stay 0
  function automatic pinmux_pkg::gpio_word_u gpio_from_pads(input logic [NP-1:0] pads);
    pinmux_pkg::gpio_word_u w;
    w = '0;
    for (int p = 0; p < NP; p++) begin
      if (gpio_bit_of_pad(p) >= 0) begin
        w.word[gpio_bit_of_pad(p)] = pads[p];
      end
    end
    return w;
  endfunction

  // Current peripheral-side outputs of the DUT
  function automatic periph_t periph_now();
    periph_t s;
    s.uart_rxd  = uart_rxd;
    s.ext_intr  = ext_intr;
    s.spim_mosi = spim_mosi;
    s.sda_in    = sda_in;
    s.scl_in    = scl_in;
    s.strap     = pad_strap;
    s.pwm_enb   = pwm_enb;
    return s;
  endfunction

  //--------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------
  task automatic compare_pads(input string what, input logic [NP-1:0] got_out,
                              input logic [NP-1:0] exp_out, input logic [NP-1:0] got_oen,
                              input logic [NP-1:0] exp_oen);
    if (got_out !== exp_out || got_oen !== exp_oen) begin
      pad_errs++;
      $display("[ERROR] %0d ns %s: pad_out %h expected %h, pad_oen %h expected %h",
               $time, what, got_out, exp_out, got_oen, exp_oen);
    end
  endtask

  task automatic compare_gpio(input string what, input pinmux_pkg::gpio_word_u got,
                              input pinmux_pkg::gpio_word_u exp);
    if (got !== exp) begin
      gpio_errs++;
      $display("[ERROR] %0d ns %s: gpio_in B %h C %h D %h expected B %h C %h D %h",
               $time, what, got.port.port_b, got.port.port_c, got.port.port_d,
               exp.port.port_b, exp.port.port_c, exp.port.port_d);
    end
  endtask

  task automatic compare_periph(input string what, input periph_t got, input periph_t exp);
    if (got !== exp) begin
      periph_errs++;
      $display("[ERROR] %0d ns %s: rxd %b intr %b mosi %b sda %b scl %b strap %h pwm %h",
               $time, what, got.uart_rxd, got.ext_intr, got.spim_mosi, got.sda_in,
               got.scl_in, got.strap, got.pwm_enb);
      $display("[ERROR] %0d ns %s: expected rxd %b intr %b mosi %b sda %b scl %b",
               $time, what, exp.uart_rxd, exp.ext_intr, exp.spim_mosi, exp.sda_in,
               exp.scl_in);
      $display("[ERROR] %0d ns %s: expected strap %h pwm %h",
               $time, what, exp.strap, exp.pwm_enb);
    end
  endtask

  // All outputs against the model
  task automatic verify_outputs(input string what);
    logic [NP-1:0] e_out;
    logic [NP-1:0] e_oen;
    periph_t       e_per;
    for (int p = 0; p < NP; p++) begin
      e_out[p] = pad_value(p);
      e_oen[p] = pad_oen_exp(p);
    end
    compare_pads(what, pad_out, e_out, pad_oen, e_oen);
    compare_gpio(what, gpio_in, gpio_from_pads(pad_in));
    // RXD1 owns pad 8 ahead of INT0
    e_per.uart_rxd[1] = m_func.uart_enb[1] ? pad_in[8] : 1'b1;
    e_per.uart_rxd[0] = m_func.uart_enb[0] ? pad_in[6] : 1'b1;
    e_per.ext_intr[1] = m_func.int_enb[1] & pad_in[9];
    e_per.ext_intr[0] = m_func.int_enb[0] & ~m_func.uart_enb[1] & pad_in[8];
    e_per.spim_mosi   = m_func.spim_enb & pad_in[19];
    e_per.sda_in      = m_func.i2cm_enb & pad_in[26];
    e_per.scl_in      = m_func.i2cm_enb & pad_in[27];
    e_per.strap       = pad_in[20:13];
    e_per.pwm_enb     = m_func.pwm_enb;
    compare_periph(what, periph_now(), e_per);
  endtask

  // Fixed values after reset
  task automatic verify_reset_state();
    periph_t e_per;
    e_per          = '0;
    e_per.uart_rxd = '1;
    e_per.strap    = pad_in[20:13];
    compare_pads("reset", pad_out, '0, pad_oen, '1);
    compare_gpio("reset", gpio_in, gpio_from_pads(pad_in));
    compare_periph("reset", periph_now(), e_per);
  endtask

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------
  task automatic drive_data();
    logic [31:0] r;
    r = rand_bits(NP);
    pad_in    <= r[NP-1:0];
    gpio_out  <= rand_bits(32);
    r = rand_bits(18);
    pwm_wfm   <= r[5:0];
    uart_txd  <= r[7:6];
    spim_ssn  <= r[11:8];
    spim_sck  <= r[12];
    spim_miso <= r[13];
    sda_out   <= r[14];
    sda_oen   <= r[15];
    scl_out   <= r[16];
    scl_oen   <= r[17];
  endtask

  // Reserved function bits held at 0
  task automatic drive_cfg(input logic func_on, input logic strap);
    logic [31:0] r;
    r = rand_bits(16);
    if (func_on) begin
      cfg_func <= {16'h0000, r[15:0]};
    end else begin
      cfg_func <= '0;
    end
    cfg_dir   <= rand_bits(32);
    cfg_strap <= strap;
  endtask

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Error counts: pads %0d, gpio %0d, peripheral %0d", pad_errs, gpio_errs,
             periph_errs);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] strap_r;
    lfsr_q      = LFSR_SEED;
    pad_errs    = 0;
    gpio_errs   = 0;
    periph_errs = 0;
    rst_n     = 1'b0;
    cfg_strap = 1'b0;
    cfg_dir   = '0;
    cfg_func  = '0;
    pad_in    = '0;
    gpio_out  = '0;
    pwm_wfm   = '0;
    uart_txd  = '0;
    spim_sck  = 1'b0;
    spim_ssn  = '0;
    spim_miso = 1'b0;
    sda_out   = 1'b0;
    sda_oen   = 1'b1;
    scl_out   = 1'b0;
    scl_oen   = 1'b1;

    // Reset held with busy configuration inputs and released on the last edge
    for (int i = 0; i < RST_CYC; i++) begin
      @(posedge clk);
      drive_data();
      drive_cfg(1'b1, 1'b1);
      if (i == RST_CYC - 1) begin
        rst_n <= 1'b1;
      end
      @(negedge clk);
      verify_reset_state();
    end

    // GPIO only
    for (int i = 0; i < GPIO_CYC; i++) begin
      @(posedge clk);
      drive_data();
      drive_cfg(1'b0, 1'b0);
      @(negedge clk);
      verify_outputs("gpio");
    end

    // Full random function word
    for (int i = 0; i < RAND_CYC; i++) begin
      @(posedge clk);
      drive_data();
      drive_cfg(1'b1, 1'b0);
      @(negedge clk);
      verify_outputs("random");
    end

    // Strap hold on
    for (int i = 0; i < STRAP_CYC; i++) begin
      @(posedge clk);
      drive_data();
      drive_cfg(1'b1, 1'b1);
      @(negedge clk);
      verify_outputs("strap");
    end

    // New word must wait one edge before reaching the pads
    for (int i = 0; i < LAT_ITER; i++) begin
      @(posedge clk);
      drive_data();
      @(negedge clk);
      verify_outputs("latency settle");
      saved_out = pad_out;
      saved_oen = pad_oen;
      @(posedge clk);
      strap_r = rand_bits(1);
      drive_cfg(1'b1, strap_r[0]);
      @(negedge clk);
      compare_pads("latency hold", pad_out, saved_out, pad_oen, saved_oen);
      verify_outputs("latency hold");
      @(posedge clk);
      @(negedge clk);
      verify_outputs("latency apply");
    end

    $display("Error counts: pads %0d, gpio %0d, peripheral %0d", pad_errs, gpio_errs,
             periph_errs);
    if (pad_errs + gpio_errs + periph_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: pinmux_top.f
logic/pinmux_pkg.sv
logic/pinmux_cfg_if.sv
logic/pinmux_cfg_decode.sv
logic/pinmux_pad_drive.sv
logic/pinmux_pad_sample.sv
logic/pinmux_top.sv
verification/pinmux_tb_clkgen.sv
verification/pinmux_tb.sv
